//--- hw/icache_tag_pkg.sv
//----------------------------------------------------------------------
// Instruction cache tag widths, set count and tag word views
//----------------------------------------------------------------------
`default_nettype none

package icache_tag_pkg;

  // Fetch address split
  localparam int ADDR_W      = 40;
  localparam int OFFSET_W    = 4;
  localparam int TAG_INDEX_W = 8;
  localparam int SETS        = 1 << TAG_INDEX_W;

  // Stored tag is everything above index and offset
  localparam int TAG_W       = ADDR_W - TAG_INDEX_W - OFFSET_W;

  // Valid bit plus tag
  localparam int WAY_ENTRY_W = 1 + TAG_W;

  // FIFO bit plus two way entries
  localparam int TAG_LINE_W  = 1 + 2 * WAY_ENTRY_W;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } way_entry_t;

  // Field order follows the SRAM write mask: fifo, way1, way0
  typedef struct packed {
    logic       fifo;
    way_entry_t way1;
    way_entry_t way0;
  } tag_fields_t;

  // One array word, seen as raw SRAM bits or as fields
  typedef union packed {
    logic [TAG_LINE_W-1:0] raw;
    tag_fields_t           fields;
  } tag_line_u;

endpackage

`default_nettype wire

//--- hw/gated_clk_cell.sv
//----------------------------------------------------------------------
// Latch-based clock gate with global, local and scan enables
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module gated_clk_cell (
  input  logic clk_in,
  input  logic global_en,
  input  logic local_en,
  input  logic pad_yy_icg_scan_en,
  output logic clk_out
);

  logic en_lat;

  // Enable settles while the clock is low
  always_latch begin
    if (!clk_in) begin
      en_lat = pad_yy_icg_scan_en | (global_en & local_en);
    end
  end

  // Latched enable is stable for the whole high phase
  assign clk_out = clk_in & en_lat;

endmodule

`default_nettype wire

//--- hw/icache_tag_spsram.sv
//----------------------------------------------------------------------
// Single-port tag SRAM model, 256 x 59, active-low controls
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module icache_tag_spsram (
  input  logic                                  clk,
  // Chip enable, active low
  input  logic                                  cen,
  // Global write enable, active low
  input  logic                                  gwen,
  // Per-bit write mask, active low
  input  logic [icache_tag_pkg::TAG_LINE_W-1:0] wen,
  input  logic [icache_tag_pkg::TAG_INDEX_W-1:0] a,
  input  logic [icache_tag_pkg::TAG_LINE_W-1:0] d,
  output logic [icache_tag_pkg::TAG_LINE_W-1:0] q
);

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------
  logic [icache_tag_pkg::TAG_LINE_W-1:0] mem [icache_tag_pkg::SETS];

  //--------------------------------------------------------------------
  // Access port
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!cen) begin
      if (!gwen) begin
        // Masked bits keep their old value
        mem[a] <= (mem[a] & wen) | (d & ~wen);
      end else begin
        // Read, q holds until the next read
        q <= mem[a];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/icache_tag_array.sv
//----------------------------------------------------------------------
// Tag array: access clock gate, SRAM polarity and tag SRAM instance
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                                   forever_cpuclk,
  input  logic                                   cp0_yy_clk_en,
  input  logic                                   pad_yy_icg_scan_en,
  input  logic                                   icache_tag_cen,
  input  logic [icache_tag_pkg::TAG_INDEX_W-1:0] icache_tag_idx,
  input  logic [2:0]                             icache_tag_wen,
  input  icache_tag_pkg::tag_line_u              icache_tag_din,
  output icache_tag_pkg::tag_line_u              icache_tag_dout
);

  logic                                  icache_tag_clk;
  logic                                  icache_tag_cen_b;
  logic                                  icache_tag_gwen_b;
  logic [icache_tag_pkg::TAG_LINE_W-1:0] icache_tag_bwen_b;
  logic [icache_tag_pkg::TAG_LINE_W-1:0] icache_tag_q;

  //--------------------------------------------------------------------
  // Clock gate, runs only on an access
  //--------------------------------------------------------------------
  gated_clk_cell x_icache_tag_icg_cell (
    .clk_in             (forever_cpuclk),
    .global_en          (cp0_yy_clk_en),
    .local_en           (icache_tag_cen),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (icache_tag_clk)
  );

  //--------------------------------------------------------------------
  // Request to SRAM polarity
  //--------------------------------------------------------------------
  assign icache_tag_cen_b  = ~icache_tag_cen;
  // Any write bit makes it a write
  assign icache_tag_gwen_b = ~(|icache_tag_wen);

  // Mask order fifo, way1, way0
  assign icache_tag_bwen_b = ~{icache_tag_wen[2],
                               {icache_tag_pkg::WAY_ENTRY_W{icache_tag_wen[1]}},
                               {icache_tag_pkg::WAY_ENTRY_W{icache_tag_wen[0]}}};

  icache_tag_spsram x_icache_tag_spsram (
    .clk  (icache_tag_clk),
    .cen  (icache_tag_cen_b),
    .gwen (icache_tag_gwen_b),
    .wen  (icache_tag_bwen_b),
    .a    (icache_tag_idx),
    .d    (icache_tag_din.raw),
    .q    (icache_tag_q)
  );

  assign icache_tag_dout.raw = icache_tag_q;

endmodule

`default_nettype wire

//--- hw/icache_tag_req.sv
//----------------------------------------------------------------------
// Tag request side: invalidate sweep, refill and lookup arbitration
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module icache_tag_req (
  input  logic                                   forever_cpuclk,
  input  logic                                   rst,
  input  logic                                   lookup_req,
  input  logic [icache_tag_pkg::ADDR_W-1:0]      lookup_addr,
  input  logic                                   refill_req,
  input  logic [icache_tag_pkg::ADDR_W-1:0]      refill_addr,
  input  logic                                   inv_req,
  input  logic                                   victim_way,
  output logic                                   busy,
  output logic                                   tag_cen,
  output logic [icache_tag_pkg::TAG_INDEX_W-1:0] tag_idx,
  output logic [2:0]                             tag_wen,
  output icache_tag_pkg::tag_line_u              tag_din,
  output logic                                   look_valid,
  output logic [icache_tag_pkg::TAG_W-1:0]       look_tag
);

  logic                                   inv_go;
  logic                                   refill_go;
  logic                                   lookup_go;
  logic [icache_tag_pkg::TAG_INDEX_W-1:0] sweep_idx;
  logic [icache_tag_pkg::TAG_INDEX_W-1:0] lookup_idx;
  logic [icache_tag_pkg::TAG_INDEX_W-1:0] refill_idx;
  logic [icache_tag_pkg::TAG_W-1:0]       lookup_tag;
  logic [icache_tag_pkg::TAG_W-1:0]       refill_tag;
  icache_tag_pkg::way_entry_t             new_entry;

  // Priority: invalidate, refill, lookup; all dropped while busy
  assign inv_go    = inv_req & ~busy;
  assign refill_go = refill_req & ~busy & ~inv_req;
  assign lookup_go = lookup_req & ~busy & ~inv_req & ~refill_req;

  // Address split into index and tag
  assign lookup_idx = lookup_addr[icache_tag_pkg::OFFSET_W +: icache_tag_pkg::TAG_INDEX_W];
  assign lookup_tag = lookup_addr[icache_tag_pkg::ADDR_W-1 -: icache_tag_pkg::TAG_W];
  assign refill_idx = refill_addr[icache_tag_pkg::OFFSET_W +: icache_tag_pkg::TAG_INDEX_W];
  assign refill_tag = refill_addr[icache_tag_pkg::ADDR_W-1 -: icache_tag_pkg::TAG_W];

  assign new_entry.valid = 1'b1;
  assign new_entry.tag   = refill_tag;

  //--------------------------------------------------------------------
  // Invalidate sweep, one set per cycle
  //--------------------------------------------------------------------
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      busy      <= 1'b0;
      sweep_idx <= '0;
    end else if (inv_go) begin
      busy      <= 1'b1;
      sweep_idx <= '0;
    end else if (busy) begin
      sweep_idx <= sweep_idx + 1'b1;
      // Last set written, release
      if (sweep_idx == icache_tag_pkg::TAG_INDEX_W'(icache_tag_pkg::SETS - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------
  // Array access select
  //--------------------------------------------------------------------
  always_comb begin
    tag_cen     = 1'b0;
    tag_idx     = lookup_idx;
    tag_wen     = 3'b000;
    tag_din.raw = '0;
    if (busy) begin
      // All-zero word, full mask
      tag_cen = 1'b1;
      tag_idx = sweep_idx;
      tag_wen = 3'b111;
    end else if (refill_go) begin
      // Same entry on both ways, mask picks the victim
      tag_cen             = 1'b1;
      tag_idx             = refill_idx;
      tag_wen             = {1'b1, victim_way, ~victim_way};
      tag_din.fields.fifo = ~victim_way;
      tag_din.fields.way1 = new_entry;
      tag_din.fields.way0 = new_entry;
    end else if (lookup_go) begin
      tag_cen = 1'b1;
    end
  end

  // Compare stage info
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      look_valid <= 1'b0;
    end else begin
      look_valid <= lookup_go;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (lookup_go) begin
      look_tag <= lookup_tag;
    end
  end

endmodule

`default_nettype wire

//--- hw/icache_tag_hit.sv
//----------------------------------------------------------------------
// Tag hit side: way compare, lookup result and refill victim
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module icache_tag_hit (
  input  logic                             forever_cpuclk,
  input  logic                             rst,
  input  logic                             look_valid,
  input  logic [icache_tag_pkg::TAG_W-1:0] look_tag,
  input  icache_tag_pkg::tag_line_u        tag_dout,
  output logic                             lookup_done,
  output logic                             lookup_hit,
  output logic                             lookup_way,
  output logic                             victim_way
);

  logic way0_hit;
  logic way1_hit;
  logic any_hit;

  // Per-way compare on the field view
  assign way0_hit = tag_dout.fields.way0.valid & (tag_dout.fields.way0.tag == look_tag);
  assign way1_hit = tag_dout.fields.way1.valid & (tag_dout.fields.way1.tag == look_tag);
  assign any_hit  = way0_hit | way1_hit;

  //--------------------------------------------------------------------
  // Result register
  //--------------------------------------------------------------------
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      lookup_done <= 1'b0;
    end else begin
      lookup_done <= look_valid;
    end
  end

  // way0 wins a double match
  always_ff @(posedge forever_cpuclk) begin
    lookup_hit <= any_hit;
    lookup_way <= ~way0_hit & way1_hit;
  end

  // FIFO bit of the last miss picks the refill way
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      victim_way <= 1'b0;
    end else if (look_valid && !any_hit) begin
      victim_way <= tag_dout.fields.fifo;
    end
  end

endmodule

`default_nettype wire

//--- hw/icache_tag_top.sv
//----------------------------------------------------------------------
// Instruction cache tag subsystem top: request, array and hit sides
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module icache_tag_top (
  input  logic                              forever_cpuclk,
  input  logic                              rst,
  input  logic                              cp0_yy_clk_en,
  input  logic                              pad_yy_icg_scan_en,
  input  logic                              lookup_req,
  input  logic [icache_tag_pkg::ADDR_W-1:0] lookup_addr,
  input  logic                              refill_req,
  input  logic [icache_tag_pkg::ADDR_W-1:0] refill_addr,
  input  logic                              inv_req,
  output logic                              busy,
  output logic                              lookup_done,
  output logic                              lookup_hit,
  output logic                              lookup_way
);

  logic                                   tag_cen;
  logic [icache_tag_pkg::TAG_INDEX_W-1:0] tag_idx;
  logic [2:0]                             tag_wen;
  icache_tag_pkg::tag_line_u              tag_din;
  icache_tag_pkg::tag_line_u              tag_dout;
  logic                                   look_valid;
  logic [icache_tag_pkg::TAG_W-1:0]       look_tag;
  logic                                   victim_way;

  // Arbitration and access forming
  icache_tag_req x_icache_tag_req (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .lookup_req     (lookup_req),
    .lookup_addr    (lookup_addr),
    .refill_req     (refill_req),
    .refill_addr    (refill_addr),
    .inv_req        (inv_req),
    .victim_way     (victim_way),
    .busy           (busy),
    .tag_cen        (tag_cen),
    .tag_idx        (tag_idx),
    .tag_wen        (tag_wen),
    .tag_din        (tag_din),
    .look_valid     (look_valid),
    .look_tag       (look_tag)
  );

  icache_tag_array x_icache_tag_array (
    .forever_cpuclk     (forever_cpuclk),
    .cp0_yy_clk_en      (cp0_yy_clk_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .icache_tag_cen     (tag_cen),
    .icache_tag_idx     (tag_idx),
    .icache_tag_wen     (tag_wen),
    .icache_tag_din     (tag_din),
    .icache_tag_dout    (tag_dout)
  );

  // Compare and victim tracking
  icache_tag_hit x_icache_tag_hit (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .look_valid     (look_valid),
    .look_tag       (look_tag),
    .tag_dout       (tag_dout),
    .lookup_done    (lookup_done),
    .lookup_hit     (lookup_hit),
    .lookup_way     (lookup_way),
    .victim_way     (victim_way)
  );

endmodule

`default_nettype wire

//--- test/tb_icache_tag_top.sv
//----------------------------------------------------------------------
// Testbench for the tag subsystem with LFSR stimulus, reference model and checker
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_icache_tag_top;

  localparam int CLK_PERIOD  = 4;
  localparam int RAND_ROUNDS = 300;
  // Lookup takes 3 cycles and refill 2
  localparam int TEST_CYCLES = 5 + icache_tag_pkg::SETS + 8 + 20 * 5 + RAND_ROUNDS * 5;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic                              forever_cpuclk;
  logic                              rst;
  logic                              cp0_yy_clk_en;
  logic                              pad_yy_icg_scan_en;
  logic                              lookup_req;
  logic [icache_tag_pkg::ADDR_W-1:0] lookup_addr;
  logic                              refill_req;
  logic [icache_tag_pkg::ADDR_W-1:0] refill_addr;
  logic                              inv_req;
  logic                              busy;
  logic                              lookup_done;
  logic                              lookup_hit;
  logic                              lookup_way;

  // Reference model with one tag word per set and the last miss victim
  icache_tag_pkg::tag_line_u         ref_line [icache_tag_pkg::SETS];
  logic                              ref_victim;
  logic [31:0]                       lfsr_state;
  int                                cyc = 0;
  int                                check_cnt;
  int                                err_cnt;
  int                                fail_cnt;

  // Pending lookups with due cycle, address and expected {hit, way}
  int                                due_q [$];
  logic [icache_tag_pkg::ADDR_W-1:0] addr_q [$];
  logic [1:0]                        exp_q [$];

  icache_tag_top u_dut (
    .forever_cpuclk     (forever_cpuclk),
    .rst                (rst),
    .cp0_yy_clk_en      (cp0_yy_clk_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .lookup_req         (lookup_req),
    .lookup_addr        (lookup_addr),
    .refill_req         (refill_req),
    .refill_addr        (refill_addr),
    .inv_req            (inv_req),
    .busy               (busy),
    .lookup_done        (lookup_done),
    .lookup_hit         (lookup_hit),
    .lookup_way         (lookup_way)
  );

  always #(CLK_PERIOD / 2) forever_cpuclk = ~forever_cpuclk;

  // Rising edge count that times the result checks
  always @(posedge forever_cpuclk) cyc <= cyc + 1;

  //--------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // Galois form with taps 32, 22, 2 and 1
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Pool of 8 tags under fixed upper bits
  function automatic logic [icache_tag_pkg::ADDR_W-1:0] make_addr(
    input logic [2:0] tsel, input logic [7:0] idx, input logic [3:0] off);
    return {20'hA5C3E, 5'd0, tsel, idx, off};
  endfunction

  function automatic logic [icache_tag_pkg::TAG_INDEX_W-1:0] index_of(
    input logic [icache_tag_pkg::ADDR_W-1:0] addr);
    return addr[icache_tag_pkg::OFFSET_W +: icache_tag_pkg::TAG_INDEX_W];
  endfunction

  function automatic logic [icache_tag_pkg::TAG_W-1:0] tag_of(
    input logic [icache_tag_pkg::ADDR_W-1:0] addr);
    return addr[icache_tag_pkg::ADDR_W-1 -: icache_tag_pkg::TAG_W];
  endfunction

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  // Expected {hit, way} with way0 checked first
  function automatic logic [1:0] predict_lookup(
    input logic [icache_tag_pkg::ADDR_W-1:0] addr);
    icache_tag_pkg::tag_line_u        line;
    logic [icache_tag_pkg::TAG_W-1:0] tag;
    line = ref_line[index_of(addr)];
    tag  = tag_of(addr);
    if (line.fields.way0.valid && line.fields.way0.tag == tag)
      return 2'b10;
    else if (line.fields.way1.valid && line.fields.way1.tag == tag)
      return 2'b11;
    return 2'b00;
  endfunction

  task automatic issue_lookup(
    input logic [icache_tag_pkg::ADDR_W-1:0] addr, output logic hit);
    logic [1:0] exp;
    @(posedge forever_cpuclk);
    #1;
    exp         = predict_lookup(addr);
    hit         = exp[1];
    lookup_req  = 1'b1;
    lookup_addr = addr;
    // Result is due in the cycle after the second edge
    due_q.push_back(cyc + 2);
    addr_q.push_back(addr);
    exp_q.push_back(exp);
    if (!exp[1])
      ref_victim = ref_line[index_of(addr)].fields.fifo;
    @(posedge forever_cpuclk);
    #1;
    lookup_req = 1'b0;
    @(posedge forever_cpuclk);
    #1;
  endtask

  task automatic refill_line(input logic [icache_tag_pkg::ADDR_W-1:0] addr);
    icache_tag_pkg::way_entry_t entry;
    logic [7:0]                 idx;
    @(posedge forever_cpuclk);
    #1;
    refill_req  = 1'b1;
    refill_addr = addr;
    idx         = index_of(addr);
    entry.valid = 1'b1;
    entry.tag   = tag_of(addr);
    // Write lands only when the array clock runs
    if (cp0_yy_clk_en || pad_yy_icg_scan_en) begin
      if (ref_victim)
        ref_line[idx].fields.way1 = entry;
      else
        ref_line[idx].fields.way0 = entry;
      ref_line[idx].fields.fifo = ~ref_victim;
    end
    @(posedge forever_cpuclk);
    #1;
    refill_req = 1'b0;
  endtask

  task automatic invalidate_all();
    int busy_cycles;
    @(posedge forever_cpuclk);
    #1;
    inv_req = 1'b1;
    @(posedge forever_cpuclk);
    #1;
    inv_req     = 1'b0;
    busy_cycles = 0;
    while (busy === 1'b1 && busy_cycles < 2 * icache_tag_pkg::SETS) begin
      busy_cycles++;
      @(posedge forever_cpuclk);
      #1;
    end
    assert (busy_cycles == icache_tag_pkg::SETS) else begin
      $display("ERR %0t: busy high for %0d cycles, expected %0d", $time, busy_cycles,
               icache_tag_pkg::SETS);
      err_cnt++;
    end
    for (int i = 0; i < icache_tag_pkg::SETS; i++)
      ref_line[i].raw = '0;
  endtask

  //--------------------------------------------------------------------
  // Result comparator
  //--------------------------------------------------------------------
  always @(negedge forever_cpuclk) begin
    if (!rst) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        check_cnt++;
        // Way only matters on a hit
        assert (lookup_done === 1'b1 && lookup_hit === exp_q[0][1] &&
                (!exp_q[0][1] || lookup_way === exp_q[0][0])) else begin
          $display("ERR %0t: lookup %h got done=%b hit=%b way=%b, expected hit=%b way=%b",
                   $time, addr_q[0], lookup_done, lookup_hit, lookup_way,
                   exp_q[0][1], exp_q[0][0]);
          err_cnt++;
        end
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
        void'(exp_q.pop_front());
      end else begin
        assert (lookup_done === 1'b0) else begin
          $display("ERR %0t: lookup_done=%b with no lookup due", $time, lookup_done);
          err_cnt++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial begin
    logic [31:0]                       r_tag;
    logic [31:0]                       r_idx;
    logic [31:0]                       r_off;
    logic [31:0]                       r_fill;
    logic [icache_tag_pkg::ADDR_W-1:0] addr_a;
    logic [icache_tag_pkg::ADDR_W-1:0] addr_b;
    logic [icache_tag_pkg::ADDR_W-1:0] addr_c;
    logic [icache_tag_pkg::ADDR_W-1:0] addr;
    logic                              hit;
    forever_cpuclk     = 1'b0;
    rst                = 1'b1;
    cp0_yy_clk_en      = 1'b1;
    pad_yy_icg_scan_en = 1'b0;
    lookup_req         = 1'b0;
    lookup_addr        = '0;
    refill_req         = 1'b0;
    refill_addr        = '0;
    inv_req            = 1'b0;
    lfsr_state         = 32'h777;
    ref_victim         = 1'b0;
    check_cnt          = 0;
    err_cnt            = 0;
    fail_cnt           = 0;
    addr_a             = make_addr(3'd1, 8'h15, 4'h0);
    addr_b             = make_addr(3'd2, 8'h15, 4'h4);
    addr_c             = make_addr(3'd3, 8'h15, 4'hC);
    repeat (5) @(posedge forever_cpuclk);
    #1;
    rst = 1'b0;

    // Sweep and then everything misses
    invalidate_all();
    for (int k = 0; k < 4; k++)
      issue_lookup(make_addr(3'(k), 8'(8'h15 + k * 8'h40), 4'(k)), hit);

    // First refill goes to way0 and the second to way1
    issue_lookup(addr_a, hit);
    refill_line(addr_a);
    issue_lookup(addr_a, hit);
    issue_lookup(addr_b, hit);
    refill_line(addr_b);
    issue_lookup(addr_b, hit);
    issue_lookup(addr_a, hit);

    // Third tag evicts the oldest line
    issue_lookup(addr_c, hit);
    refill_line(addr_c);
    issue_lookup(addr_a, hit);
    issue_lookup(addr_b, hit);
    issue_lookup(addr_c, hit);

    // Random mix over 8 tags and 4 sets
    for (int n = 0; n < RAND_ROUNDS; n++) begin
      draw_bits(3, r_tag);
      draw_bits(2, r_idx);
      draw_bits(4, r_off);
      draw_bits(2, r_fill);
      addr = make_addr(r_tag[2:0], {r_idx[1:0], 6'h15}, r_off[3:0]);
      issue_lookup(addr, hit);
      // Most misses get their refill
      if (!hit && r_fill[1:0] != 2'b00)
        refill_line(addr);
    end

    // Clock enable low drops the refill
    addr_a = make_addr(3'd5, 8'h80, 4'h8);
    addr_b = make_addr(3'd6, 8'h80, 4'h2);
    issue_lookup(addr_a, hit);
    cp0_yy_clk_en = 1'b0;
    refill_line(addr_a);
    cp0_yy_clk_en = 1'b1;
    issue_lookup(addr_a, hit);
    refill_line(addr_a);
    issue_lookup(addr_a, hit);

    // Scan enable forces the gate open
    cp0_yy_clk_en      = 1'b0;
    pad_yy_icg_scan_en = 1'b1;
    issue_lookup(addr_b, hit);
    refill_line(addr_b);
    issue_lookup(addr_b, hit);
    issue_lookup(addr_a, hit);
    cp0_yy_clk_en      = 1'b1;
    pad_yy_icg_scan_en = 1'b0;

    repeat (2) @(posedge forever_cpuclk);
    if (due_q.size() != 0) begin
      $display("Lookup results were never seen for %0d request(s)", due_q.size());
      fail_cnt++;
    end
    $display("Checks: %0d, value errors: %0d, other failures: %0d",
             check_cnt, err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/icache_tag_pkg.sv
hw/gated_clk_cell.sv
hw/icache_tag_spsram.sv
hw/icache_tag_array.sv
hw/icache_tag_req.sv
hw/icache_tag_hit.sv
hw/icache_tag_top.sv
test/tb_icache_tag_top.sv

//--- Bender.yml
package:
  name: icache_tag

sources:
  - hw/icache_tag_pkg.sv
  - hw/gated_clk_cell.sv
  - hw/icache_tag_spsram.sv
  - hw/icache_tag_array.sv
  - hw/icache_tag_req.sv
  - hw/icache_tag_hit.sv
  - hw/icache_tag_top.sv
  - target: test
    files:
      - test/tb_icache_tag_top.sv
